// ==== common/tenyr_pkg.sv ====
`default_nettype none

package tenyr_pkg;

    // Widths fixed by the instruction set
    localparam int WORD_W  = 32;
    localparam int REG_W   = 4;
    localparam int IMM_W   = 12;
    localparam int OP_W    = 4;
    localparam int DEREF_W = 2;

    typedef logic [WORD_W-1:0]         word_t;     // Data, address and insn word
    typedef logic [REG_W-1:0]          reg_idx_t;
    typedef logic signed [IMM_W-1:0]   imm_t;
    typedef logic [OP_W-1:0]           op_t;
    typedef logic [DEREF_W-1:0]        deref_t;

    // Instruction field positions
    localparam int CLASS_BIT = 31;
    localparam int TYPE_BIT  = 30;
    localparam int DEREF_LSB = 28;
    localparam int Z_LSB     = 24;
    localparam int X_LSB     = 20;
    localparam int Y_LSB     = 16;
    localparam int OP_LSB    = 12;
    localparam int IMM_LSB   = 0;

    // Op codes with 4 and 15 left reserved
    localparam op_t OP_OR   = 4'd0;
    localparam op_t OP_AND  = 4'd1;
    localparam op_t OP_ADD  = 4'd2;
    localparam op_t OP_MUL  = 4'd3;
    localparam op_t OP_SHL  = 4'd5;
    localparam op_t OP_LT   = 4'd6;    // Signed
    localparam op_t OP_EQ   = 4'd7;
    localparam op_t OP_GT   = 4'd8;    // Signed
    localparam op_t OP_ANDN = 4'd9;
    localparam op_t OP_XOR  = 4'd10;
    localparam op_t OP_SUB  = 4'd11;
    localparam op_t OP_XNOR = 4'd12;
    localparam op_t OP_SHR  = 4'd13;   // Logical
    localparam op_t OP_NE   = 4'd14;

    // Deref modes
    localparam deref_t DEREF_REG       = 2'b00;  //  Z  <-  rhs
    localparam deref_t DEREF_LOAD      = 2'b01;  //  Z  <- [rhs]
    localparam deref_t DEREF_STORE_Z   = 2'b10;  // [Z] <-  rhs
    localparam deref_t DEREF_STORE_RHS = 2'b11;  // [rhs] <- Z

    localparam reg_idx_t REG_PC       = 4'd15;
    localparam word_t    RESET_VECTOR = 32'h0000_0000;

    typedef enum logic [1:0] {
        FS_ISSUE,
        FS_WAIT,
        FS_HALT
    } fetch_state_e;

    // Decode to execute
    typedef struct packed {
        deref_t   deref;
        reg_idx_t z_idx;
        word_t    x_val;
        word_t    y_val;
        word_t    z_val;
        op_t      op;
        imm_t     imm;
        logic     type_bit;
        word_t    addr;
    } decoded_t;

    // Execute to memory
    typedef struct packed {
        deref_t   deref;
        reg_idx_t z_idx;
        word_t    z_val;
        word_t    rhs;
        word_t    addr;
    } exec_t;

    // Register writeback
    typedef struct packed {
        logic     we;
        reg_idx_t idx;
        word_t    val;
    } wb_t;

endpackage

`default_nettype wire

// ==== core/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import tenyr_pkg::*;
(
    input  wire        i_clk,
    input  wire        reset_n,
    input  wire        i_wb_valid,
    input  wire wb_t   i_wb,
    input  wire        i_illegal,
    input  wire word_t i_insn_data,
    output logic       o_insn_stb,
    output word_t      o_insn_addr,
    output logic       o_insn_valid,
    output word_t      o_insn,
    output word_t      o_pc,
    output logic       o_halt
);

    fetch_state_e state;
    word_t        pc;
    logic         insn_stb;
    logic         insn_valid;
    logic         jump;

    // Write to r15 redirects the next fetch
    assign jump = i_wb.we && (i_wb.idx == REG_PC);

    always_ff @(posedge i_clk) begin
        if (reset_n) begin
            state      <= FS_ISSUE;
            pc         <= RESET_VECTOR;
            insn_stb   <= 1'b0;
            insn_valid <= 1'b0;
        end else begin
            insn_stb   <= 1'b0;
            insn_valid <= insn_stb;      // Memory answers one cycle later
            case (state)
                FS_ISSUE: begin
                    insn_stb <= 1'b1;    // First fetch after reset
                    state    <= FS_WAIT;
                end
                FS_WAIT: begin
                    if (i_illegal) begin
                        state <= FS_HALT;
                    end else if (i_wb_valid) begin
                        pc       <= jump ? i_wb.val : pc + 1'b1;
                        insn_stb <= 1'b1;
                    end
                end
                default: state <= FS_HALT;   // Sticky until reset
            endcase
        end
    end

    assign o_insn_stb   = insn_stb;
    assign o_insn_addr  = pc;
    assign o_insn_valid = insn_valid;
    assign o_insn       = i_insn_data;
    assign o_pc         = pc;
    assign o_halt       = (state == FS_HALT);

endmodule

`default_nettype wire

// ==== core/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import tenyr_pkg::*;
(
    input  wire          i_clk,
    input  wire          reset_n,
    input  wire          i_insn_valid,
    input  wire word_t   i_insn,
    input  wire word_t   i_pc,
    output reg_idx_t     o_rd_x,
    output reg_idx_t     o_rd_y,
    output reg_idx_t     o_rd_z,
    input  wire word_t   i_val_x,
    input  wire word_t   i_val_y,
    input  wire word_t   i_val_z,
    output logic         o_illegal,
    output logic         o_dec_valid,
    output decoded_t     o_dec
);

    logic is_class1;

    assign is_class1 = i_insn[CLASS_BIT];

    // Register file read indices straight from the word
    assign o_rd_x = i_insn[X_LSB +: REG_W];
    assign o_rd_y = i_insn[Y_LSB +: REG_W];
    assign o_rd_z = i_insn[Z_LSB +: REG_W];

    assign o_illegal = i_insn_valid && is_class1;

    always_ff @(posedge i_clk) begin
        if (reset_n)
            o_dec_valid <= 1'b0;
        else
            o_dec_valid <= i_insn_valid && !is_class1;
    end

    always_ff @(posedge i_clk) begin
        if (i_insn_valid) begin
            o_dec.deref    <= i_insn[DEREF_LSB +: DEREF_W];
            o_dec.z_idx    <= o_rd_z;
            o_dec.x_val    <= i_val_x;
            o_dec.y_val    <= i_val_y;
            o_dec.z_val    <= i_val_z;     // Needed by the store modes
            o_dec.op       <= i_insn[OP_LSB +: OP_W];
            o_dec.imm      <= i_insn[IMM_LSB +: IMM_W];
            o_dec.type_bit <= i_insn[TYPE_BIT];
            o_dec.addr     <= i_pc;
        end
    end

endmodule

`default_nettype wire

// ==== core/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import tenyr_pkg::*;
(
    input  wire           i_clk,
    input  wire           reset_n,
    input  wire word_t    i_pc,
    input  wire reg_idx_t i_rd_x,
    input  wire reg_idx_t i_rd_y,
    input  wire reg_idx_t i_rd_z,
    output word_t         o_val_x,
    output word_t         o_val_y,
    output word_t         o_val_z,
    input  wire           i_wb_valid,
    input  wire wb_t      i_wb
);

    word_t regs [1:14];   // r0 and r15 are not stored here
    word_t pc_plus1;

    assign pc_plus1 = i_pc + 1'b1;

    function automatic word_t read_reg(input reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (idx == REG_PC)
            return pc_plus1;
        else
            return regs[idx];
    endfunction

    assign o_val_x = read_reg(i_rd_x);
    assign o_val_y = read_reg(i_rd_y);
    assign o_val_z = read_reg(i_rd_z);

    always_ff @(posedge i_clk) begin
        if (reset_n) begin
            for (int i = 1; i <= 14; i++)
                regs[i] <= '0;
        end else if (i_wb_valid && i_wb.we && i_wb.idx != '0 && i_wb.idx != REG_PC) begin
            regs[i_wb.idx] <= i_wb.val;   // PC writes are taken by fetch
        end
    end

endmodule

`default_nettype wire

// ==== core/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage
    import tenyr_pkg::*;
(
    input  wire           i_clk,
    input  wire           reset_n,
    input  wire           i_dec_valid,
    input  wire decoded_t i_dec,
    output logic          o_ex_valid,
    output exec_t         o_ex
);

    word_t imm_ext;
    word_t x;
    word_t o;
    word_t a;
    word_t op_res;
    logic  [4:0] shamt;

    assign imm_ext = {{(WORD_W-IMM_W){i_dec.imm[IMM_W-1]}}, i_dec.imm};

    // Type 0 takes Y as operand and imm as addend, type 1 swaps them
    assign x     = i_dec.x_val;
    assign o     = i_dec.type_bit ? imm_ext : i_dec.y_val;
    assign a     = i_dec.type_bit ? i_dec.y_val : imm_ext;
    assign shamt = o[4:0];

    always_comb begin
        case (i_dec.op)
            OP_OR:   op_res = x | o;
            OP_AND:  op_res = x & o;
            OP_ADD:  op_res = x + o;
            OP_MUL:  op_res = x * o;                              // Low word only
            OP_SHL:  op_res = x << shamt;
            OP_LT:   op_res = {WORD_W{$signed(x) < $signed(o)}};  // All ones when true
            OP_EQ:   op_res = {WORD_W{x == o}};
            OP_GT:   op_res = {WORD_W{$signed(x) > $signed(o)}};
            OP_ANDN: op_res = x & ~o;
            OP_XOR:  op_res = x ^ o;
            OP_SUB:  op_res = x - o;
            OP_XNOR: op_res = x ^ ~o;
            OP_SHR:  op_res = x >> shamt;
            OP_NE:   op_res = {WORD_W{x != o}};
            default: op_res = '0;                                 // Reserved ops
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (reset_n)
            o_ex_valid <= 1'b0;
        else
            o_ex_valid <= i_dec_valid;
    end

    always_ff @(posedge i_clk) begin
        if (i_dec_valid) begin
            o_ex.deref <= i_dec.deref;
            o_ex.z_idx <= i_dec.z_idx;
            o_ex.z_val <= i_dec.z_val;
            o_ex.rhs   <= op_res + a;
            o_ex.addr  <= i_dec.addr;
        end
    end

endmodule

`default_nettype wire

// ==== core/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import tenyr_pkg::*;
(
    input  wire         i_clk,
    input  wire         reset_n,
    input  wire         i_ex_valid,
    input  wire exec_t  i_ex,
    output logic        o_mem_rd_stb,
    output logic        o_mem_wr_stb,
    output word_t       o_mem_addr,
    output word_t       o_mem_wr_data,
    input  wire word_t  i_mem_rd_data,
    output logic        o_wb_valid,
    output wb_t         o_wb
);

    logic     wb_valid;
    deref_t   deref_q;
    reg_idx_t z_idx_q;
    word_t    rhs_q;
    logic     is_store;

    assign is_store = (i_ex.deref == DEREF_STORE_Z) || (i_ex.deref == DEREF_STORE_RHS);

    // Data port strobes in the cycle execute hands over
    assign o_mem_rd_stb = i_ex_valid && (i_ex.deref == DEREF_LOAD);
    assign o_mem_wr_stb = i_ex_valid && is_store;

    // [Z] <- rhs uses Z as address, the other modes address by rhs
    assign o_mem_addr    = (i_ex.deref == DEREF_STORE_Z) ? i_ex.z_val : i_ex.rhs;
    assign o_mem_wr_data = (i_ex.deref == DEREF_STORE_Z) ? i_ex.rhs : i_ex.z_val;

    always_ff @(posedge i_clk) begin
        if (reset_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= i_ex_valid;
    end

    always_ff @(posedge i_clk) begin
        if (i_ex_valid) begin
            deref_q <= i_ex.deref;
            z_idx_q <= i_ex.z_idx;
            rhs_q   <= i_ex.rhs;
        end
    end

    // Read data shows up in the writeback cycle
    assign o_wb_valid = wb_valid;
    assign o_wb.we    = (deref_q == DEREF_REG) || (deref_q == DEREF_LOAD);
    assign o_wb.idx   = z_idx_q;
    assign o_wb.val   = (deref_q == DEREF_LOAD) ? i_mem_rd_data : rhs_q;

endmodule

`default_nettype wire

// ==== core/tenyr_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tenyr_core
    import tenyr_pkg::*;
(
    input  wire        i_clk,
    input  wire        reset_n,

    // Instruction port
    output logic       o_insn_stb,
    output word_t      o_insn_addr,
    input  wire word_t i_insn_data,

    // Data port
    output logic       o_mem_rd_stb,
    output logic       o_mem_wr_stb,
    output word_t      o_mem_addr,
    output word_t      o_mem_wr_data,
    input  wire word_t i_mem_rd_data,

    output logic       o_halt
);

    logic     insn_valid;
    word_t    insn;
    word_t    pc;
    logic     illegal;

    reg_idx_t rd_x;
    reg_idx_t rd_y;
    reg_idx_t rd_z;
    word_t    val_x;
    word_t    val_y;
    word_t    val_z;

    logic     dec_valid;
    decoded_t dec;
    logic     ex_valid;
    exec_t    ex;
    logic     wb_valid;
    wb_t      wb;

    fetch_stage fetch_i (
        .i_clk        (i_clk),
        .reset_n      (reset_n),
        .i_wb_valid   (wb_valid),
        .i_wb         (wb),
        .i_illegal    (illegal),
        .i_insn_data  (i_insn_data),
        .o_insn_stb   (o_insn_stb),
        .o_insn_addr  (o_insn_addr),
        .o_insn_valid (insn_valid),
        .o_insn       (insn),
        .o_pc         (pc),
        .o_halt       (o_halt)
    );

    decode_stage decode_i (
        .i_clk        (i_clk),
        .reset_n      (reset_n),
        .i_insn_valid (insn_valid),
        .i_insn       (insn),
        .i_pc         (pc),
        .o_rd_x       (rd_x),
        .o_rd_y       (rd_y),
        .o_rd_z       (rd_z),
        .i_val_x      (val_x),
        .i_val_y      (val_y),
        .i_val_z      (val_z),
        .o_illegal    (illegal),
        .o_dec_valid  (dec_valid),
        .o_dec        (dec)
    );

    reg_file regs_i (
        .i_clk      (i_clk),
        .reset_n    (reset_n),
        .i_pc       (pc),
        .i_rd_x     (rd_x),
        .i_rd_y     (rd_y),
        .i_rd_z     (rd_z),
        .o_val_x    (val_x),
        .o_val_y    (val_y),
        .o_val_z    (val_z),
        .i_wb_valid (wb_valid),
        .i_wb       (wb)
    );

    exec_stage exec_i (
        .i_clk       (i_clk),
        .reset_n     (reset_n),
        .i_dec_valid (dec_valid),
        .i_dec       (dec),
        .o_ex_valid  (ex_valid),
        .o_ex        (ex)
    );

    mem_stage mem_i (
        .i_clk         (i_clk),
        .reset_n       (reset_n),
        .i_ex_valid    (ex_valid),
        .i_ex          (ex),
        .o_mem_rd_stb  (o_mem_rd_stb),
        .o_mem_wr_stb  (o_mem_wr_stb),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wr_data (o_mem_wr_data),
        .i_mem_rd_data (i_mem_rd_data),
        .o_wb_valid    (wb_valid),
        .o_wb          (wb)
    );

endmodule

`default_nettype wire

// ==== dv/tenyr_core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module tenyr_core_assert (
    input wire i_clk,
    input wire reset_n,
    input wire i_insn_stb,
    input wire i_mem_rd_stb,
    input wire i_mem_wr_stb,
    input wire i_halt
);

    int err_count = 0;   // Failed assertions so far

    a_one_data_stb: assert property (@(posedge i_clk) disable iff (reset_n)
        !(i_mem_rd_stb && i_mem_wr_stb))
        else begin
            err_count++;
            $error("read and write strobes together");
        end

    a_no_fetch_halted: assert property (@(posedge i_clk) disable iff (reset_n)
        i_halt |-> !i_insn_stb)
        else begin
            err_count++;
            $error("fetch while halted");
        end

    // Only an access already past execute may overlap the first halt cycle
    a_no_data_halted: assert property (@(posedge i_clk) disable iff (reset_n)
        i_halt && $past(i_halt) |-> !(i_mem_rd_stb || i_mem_wr_stb))
        else begin
            err_count++;
            $error("data strobe while halted");
        end

    a_halt_sticky: assert property (@(posedge i_clk) disable iff (reset_n)
        !$fell(i_halt))
        else begin
            err_count++;
            $error("halt fell without reset");
        end

    a_fetch_spacing: assert property (@(posedge i_clk) disable iff (reset_n)
        i_insn_stb |=> !i_insn_stb ##1 !i_insn_stb ##1 !i_insn_stb ##1 !i_insn_stb
                       ##1 (i_insn_stb || i_halt))
        else begin
            err_count++;
            $error("fetches not five cycles apart");
        end

endmodule

bind tenyr_core tenyr_core_assert core_assert_i (
    .i_clk        (i_clk),
    .reset_n      (reset_n),
    .i_insn_stb   (o_insn_stb),
    .i_mem_rd_stb (o_mem_rd_stb),
    .i_mem_wr_stb (o_mem_wr_stb),
    .i_halt       (o_halt)
);

`default_nettype wire

// ==== dv/tb_tenyr_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tenyr_core
    import tenyr_pkg::*;
();

    logic  i_clk;
    logic  reset_n;
    logic  o_insn_stb;
    word_t o_insn_addr;
    word_t i_insn_data;
    logic  o_mem_rd_stb;
    logic  o_mem_wr_stb;
    word_t o_mem_addr;
    word_t o_mem_wr_data;
    word_t i_mem_rd_data;
    logic  o_halt;

    word_t rom        [0:255];
    word_t ram        [0:63];     // Data RAM the DUT talks to
    word_t model_ram  [0:63];     // ISA model view of the same RAM
    word_t model_regs [0:15];
    word_t model_pc;
    logic  halted;

    tenyr_core dut_i (
        .i_clk         (i_clk),
        .reset_n       (reset_n),
        .o_insn_stb    (o_insn_stb),
        .o_insn_addr   (o_insn_addr),
        .i_insn_data   (i_insn_data),
        .o_mem_rd_stb  (o_mem_rd_stb),
        .o_mem_wr_stb  (o_mem_wr_stb),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wr_data (o_mem_wr_data),
        .i_mem_rd_data (i_mem_rd_data),
        .o_halt        (o_halt)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic word_t rom_word(input word_t addr);
        if (addr < 256)
            return rom[addr[7:0]];
        return 32'hFFFF_FFFF;     // Past the ROM reads as illegal
    endfunction

    function automatic word_t fill_word(input int idx);
        return (word_t'(idx) * 32'h0101_0101) ^ 32'hA5C3_0F00;
    endfunction

    function automatic word_t read_model_reg(input reg_idx_t idx);
        if (idx == 4'd0)
            return 32'h0;
        if (idx == REG_PC)
            return model_pc + 32'd1;
        return model_regs[idx];
    endfunction

    function automatic word_t apply_op(input op_t op, input word_t x, input word_t o);
        case (op)
            OP_OR:   return x | o;
            OP_AND:  return x & o;
            OP_ADD:  return x + o;
            OP_MUL:  return x * o;
            OP_SHL:  return x << o[4:0];
            OP_LT:   return ($signed(x) < $signed(o)) ? ~32'h0 : 32'h0;
            OP_EQ:   return (x == o) ? ~32'h0 : 32'h0;
            OP_GT:   return ($signed(x) > $signed(o)) ? ~32'h0 : 32'h0;
            OP_ANDN: return x & ~o;
            OP_XOR:  return x ^ o;
            OP_SUB:  return x - o;
            OP_XNOR: return ~(x ^ o);
            OP_SHR:  return x >> o[4:0];
            OP_NE:   return (x != o) ? ~32'h0 : 32'h0;
            default: return 32'h0;     // Ops 4 and 15
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Random legal words, a few forward jumps, then the illegal word
    task automatic build_program();
        word_t w;
        int    tgt;
        for (int i = 0; i < 256; i++)
            rom[i] = 32'hFFFF_FFFF;
        for (int i = 0; i < 200; i++) begin
            if (i % 37 == 20 && i < 192) begin
                tgt = i + 2 + $urandom_range(3, 0);
                w = 32'h0;                          // Type 0, deref 00, op OR, X = Y = r0
                w[Z_LSB +: REG_W]     = REG_PC;
                w[IMM_LSB +: IMM_W]   = tgt[11:0];
            end else begin
                w = $urandom;
                w[CLASS_BIT]          = 1'b0;
                w[Z_LSB +: REG_W]     = $urandom_range(14, 0);
                // Sweep op, type and mode so both store modes meet every op and type
                w[OP_LSB +: OP_W]       = i[3:0];
                w[TYPE_BIT]             = i[4];
                w[DEREF_LSB +: DEREF_W] = i[6:5];
            end
            rom[i] = w;
        end
    endtask

    task automatic wait_for_fetch();
        int n;
        n = 0;
        while (o_insn_stb !== 1'b1 && n < 20) begin
            @(negedge i_clk);
            n++;
        end
        if (o_insn_stb !== 1'b1)
            abort_run("Timeout: no instruction fetch within 20 cycles");
    endtask

    task automatic run_insn();
        word_t    insn;
        word_t    x_v, y_v, z_v, imm_v, o_v, a_v, rhs;
        word_t    acc_addr, acc_data, wb_val, next_pc;
        reg_idx_t zi;
        deref_t   mode;
        logic     exp_rd, exp_wr;

        insn = rom_word(model_pc);
        if (insn[CLASS_BIT]) begin
            // No access, halt from cycle 2, and no fetch for 20 cycles
            for (int cyc = 1; cyc <= 20; cyc++) begin
                @(negedge i_clk);
                check_bit("o_insn_stb", o_insn_stb, 1'b0);
                check_bit("o_mem_rd_stb", o_mem_rd_stb, 1'b0);
                check_bit("o_mem_wr_stb", o_mem_wr_stb, 1'b0);
                check_bit("o_halt", o_halt, cyc >= 2);
            end
            halted = 1'b1;
        end else begin
            zi    = insn[Z_LSB +: REG_W];
            mode  = insn[DEREF_LSB +: DEREF_W];
            x_v   = read_model_reg(insn[X_LSB +: REG_W]);
            y_v   = read_model_reg(insn[Y_LSB +: REG_W]);
            z_v   = read_model_reg(zi);
            imm_v = {{20{insn[11]}}, insn[11:0]};
            o_v   = insn[TYPE_BIT] ? imm_v : y_v;
            a_v   = insn[TYPE_BIT] ? y_v : imm_v;
            rhs   = apply_op(insn[OP_LSB +: OP_W], x_v, o_v) + a_v;

            exp_rd   = (mode == DEREF_LOAD);
            exp_wr   = mode[1];
            acc_addr = (mode == DEREF_STORE_Z) ? z_v : rhs;
            acc_data = (mode == DEREF_STORE_Z) ? rhs : z_v;
            for (int cyc = 1; cyc <= 4; cyc++) begin
                @(negedge i_clk);
                check_bit("o_insn_stb", o_insn_stb, 1'b0);
                check_bit("o_halt", o_halt, 1'b0);
                check_bit("o_mem_rd_stb", o_mem_rd_stb, exp_rd && cyc == 3);
                check_bit("o_mem_wr_stb", o_mem_wr_stb, exp_wr && cyc == 3);
                if (cyc == 3 && (exp_rd || exp_wr))
                    check_word("o_mem_addr", o_mem_addr, acc_addr);
                if (cyc == 3 && exp_wr)
                    check_word("o_mem_wr_data", o_mem_wr_data, acc_data);
            end

            next_pc = model_pc + 32'd1;
            wb_val  = rhs;
            case (mode)
                DEREF_LOAD:    wb_val = model_ram[rhs[5:0]];
                DEREF_STORE_Z: model_ram[z_v[5:0]] = rhs;
                DEREF_STORE_RHS: model_ram[rhs[5:0]] = z_v;
                default: ;
            endcase
            if (!mode[1]) begin
                if (zi == REG_PC)
                    next_pc = wb_val;           // Jump
                else if (zi != 4'd0)
                    model_regs[zi] = wb_val;
            end
            model_pc = next_pc;
        end
    endtask

    // Instruction ROM and data RAM answer one cycle after the strobe
    always begin : memory_model
        logic  insn_req;
        logic  rd_req;
        word_t insn_addr_q;
        word_t rd_addr_q;
        @(negedge i_clk);
        insn_req    = (o_insn_stb === 1'b1);
        rd_req      = (o_mem_rd_stb === 1'b1);
        insn_addr_q = o_insn_addr;
        rd_addr_q   = o_mem_addr;
        if (o_mem_wr_stb === 1'b1)
            ram[o_mem_addr[5:0]] = o_mem_wr_data;    // Wraps into 64 words
        @(posedge i_clk);
        #1;
        if (insn_req)
            i_insn_data = rom_word(insn_addr_q);
        if (rd_req)
            i_mem_rd_data = ram[rd_addr_q[5:0]];
    end

    initial begin
        void'($urandom(3));
        reset_n       = 1'b1;
        i_insn_data   = 32'h0;
        i_mem_rd_data = 32'h0;
        halted        = 1'b0;
        build_program();
        for (int i = 0; i < 64; i++) begin
            ram[i]       = fill_word(i);
            model_ram[i] = ram[i];
        end
        for (int i = 0; i < 16; i++)
            model_regs[i] = 32'h0;
        model_pc = RESET_VECTOR;

        repeat (5) @(posedge i_clk);
        #1 reset_n = 1'b0;

        for (int n = 0; n < 300 && !halted; n++) begin
            wait_for_fetch();
            check_word("o_insn_addr", o_insn_addr, model_pc);
            run_insn();
        end
        if (!halted)
            abort_run("Program never reached the illegal word");

        if (dut_i.core_assert_i.err_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("Bound assertions reported failures");
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
common/tenyr_pkg.sv
core/fetch_stage.sv
core/decode_stage.sv
core/reg_file.sv
core/exec_stage.sv
core/mem_stage.sv
core/tenyr_core.sv
dv/tenyr_core_assert.sv
dv/tb_tenyr_core.sv

// ==== Bender.yml ====
package:
  name: tenyr_core

sources:
  # Shared package first, then the stages and the top level
  - common/tenyr_pkg.sv
  - core/fetch_stage.sv
  - core/decode_stage.sv
  - core/reg_file.sv
  - core/exec_stage.sv
  - core/mem_stage.sv
  - core/tenyr_core.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - dv/tenyr_core_assert.sv
      - dv/tb_tenyr_core.sv
